/* Bender.yml */
package:
  name: zxuno_io

sources:
  - zxuno_pkg.sv
  - io_port_decoder.sv
  - spi_master.sv
  - kempston_joy.sv
  - ula_port_fe.sv
  - tld_zxuno_io.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_tld_zxuno_io.sv

/* io_port_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module io_port_decoder (
   input  wire        clk,
   input  wire        arst_n,
   input  wire [15:0] port_addr,
   input  wire        iorq_wr,
   input  wire        iorq_rd,
   input  wire [7:0]  ula_rd_byte,
   input  wire [7:0]  joy_byte,
   input  wire [7:0]  spi_rx_byte,
   output logic       ula_wr,
   output logic       cs_wr,
   output logic       spi_wr,
   output logic [7:0] rd_data,
   output logic       rd_valid
);

   zxuno_pkg::io_target_e target;
   logic [7:0]            rd_mux;

   //////////////////////////////
   // Address classification
   //////////////////////////////

   // Full low-byte matches win over the FE partial decode
   always_comb begin
      if (port_addr[7:0] == zxuno_pkg::port_kempston) begin
         target = zxuno_pkg::joy;
      end else if (port_addr[7:0] == zxuno_pkg::port_spi_cs) begin
         target = zxuno_pkg::spi_cs;
      end else if (port_addr[7:0] == zxuno_pkg::port_spi_data) begin
         target = zxuno_pkg::spi_data;
      end else if (!port_addr[zxuno_pkg::port_fe_bit]) begin
         target = zxuno_pkg::ula;
      end else begin
         target = zxuno_pkg::none;
      end
   end

   // Write strobes, same cycle as iorq_wr
   assign ula_wr = iorq_wr && (target == zxuno_pkg::ula);
   assign cs_wr  = iorq_wr && (target == zxuno_pkg::spi_cs);
   assign spi_wr = iorq_wr && (target == zxuno_pkg::spi_data);

   // Read source select
   // E7 is write only
   always_comb begin
      case (target)
         zxuno_pkg::ula:      rd_mux = ula_rd_byte;
         zxuno_pkg::joy:      rd_mux = joy_byte;
         zxuno_pkg::spi_data: rd_mux = spi_rx_byte;
         default:             rd_mux = zxuno_pkg::idle_read_value;
      endcase
   end

   //////////////////////////////
   // Read response
   //////////////////////////////

   // One-cycle valid after the strobe
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= iorq_rd;
      end
   end

   // Data held until next read
   always_ff @(posedge clk) begin
      if (iorq_rd) begin
         rd_data <= rd_mux;
      end
   end

   // Z80 never issues both IORQ strobes at once
   assert property (@(posedge clk) disable iff (!arst_n) !(iorq_wr && iorq_rd));

endmodule

`default_nettype wire

/* kempston_joy.sv */
`timescale 1ns/1ps
`default_nettype none

module kempston_joy (
   input  wire        clk,
   input  wire        arst_n,
   input  wire        joyup,
   input  wire        joydown,
   input  wire        joyleft,
   input  wire        joyright,
   input  wire        joyfire,
   output logic [7:0] joy_byte
);

   // Pins gathered in Kempston bit order
   logic [4:0] pins_raw;
   logic [4:0] pins_meta;
   logic [4:0] pins_sync;

   assign pins_raw = {joyfire, joyup, joydown, joyleft, joyright};

   // Two-flop synchroniser, resets to released
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pins_meta <= '1;
         pins_sync <= '1;
      end else begin
         pins_meta <= pins_raw;
         pins_sync <= pins_meta;
      end
   end

   // Kempston is active high, upper bits read 0
   assign joy_byte = {3'b000, ~pins_sync};

endmodule

`default_nettype wire

/* spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master (
   input  wire        clk,
   input  wire        arst_n,
   input  wire        cs_wr,
   input  wire        spi_wr,
   input  wire [7:0]  wr_data,
   input  wire        sd_miso,
   input  wire        flash_miso,
   output logic [7:0] spi_rx_byte,
   output logic       spi_busy,
   output logic       sd_cs_n,
   output logic       flash_cs_n,
   output logic       sclk,
   output logic       mosi,
   output logic       testled
);

   localparam int unsigned cnt_w = $clog2(zxuno_pkg::spi_bits);

   zxuno_pkg::spi_state_e             state;
   zxuno_pkg::spi_state_e             state_nxt;
   logic [cnt_w-1:0]                  bit_cnt;
   logic [1:0]                        cs_sel;
   logic [zxuno_pkg::spi_bits-1:0]    tx_shift;
   logic [zxuno_pkg::spi_bits-1:0]    rx_shift;
   logic                              flash_sel;
   logic                              sd_sel;
   logic                              miso;
   logic                              last_bit;

   //////////////////////////////
   // Chip selects
   //////////////////////////////

   // cs_sel holds 1 for a selected device
   // Flash wins if both are asked for
   assign flash_sel  = cs_sel[zxuno_pkg::cs_flash_bit];
   assign sd_sel     = cs_sel[zxuno_pkg::cs_sd_bit] & ~flash_sel;
   assign flash_cs_n = ~flash_sel;
   assign sd_cs_n    = ~sd_sel;

   // Shared data line, flash has the bus while selected
   assign miso = flash_cs_n ? sd_miso : flash_miso;

   assign mosi     = tx_shift[zxuno_pkg::spi_bits-1];
   assign spi_busy = (state != zxuno_pkg::idle);
   assign last_bit = (bit_cnt == cnt_w'(zxuno_pkg::spi_bits - 1));

   //////////////////////////////
   // Shift FSM
   //////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         zxuno_pkg::idle: begin
            // Writes during a transfer never reach here
            if (spi_wr) begin
               state_nxt = zxuno_pkg::shift_low;
            end
         end
         zxuno_pkg::shift_low: begin
            state_nxt = zxuno_pkg::shift_high;
         end
         zxuno_pkg::shift_high: begin
            state_nxt = last_bit ? zxuno_pkg::idle : zxuno_pkg::shift_low;
         end
         default: begin
            state_nxt = zxuno_pkg::idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= zxuno_pkg::idle;
         sclk     <= 1'b0;
         bit_cnt  <= '0;
         cs_sel   <= 2'b00;
         tx_shift <= '1;
         testled  <= 1'b0;
      end else begin
         state <= state_nxt;
         // Registered so the pin follows the state with no glitch
         sclk  <= (state_nxt == zxuno_pkg::shift_high);
         // LED marks any SPI device in use
         testled <= ~sd_cs_n | ~flash_cs_n;
         if (cs_wr) begin
            cs_sel[zxuno_pkg::cs_sd_bit]    <= ~wr_data[zxuno_pkg::cs_sd_bit];
            cs_sel[zxuno_pkg::cs_flash_bit] <= ~wr_data[zxuno_pkg::cs_flash_bit];
         end
         if (state == zxuno_pkg::idle && spi_wr) begin
            tx_shift <= wr_data;
            bit_cnt  <= '0;
         end else if (state == zxuno_pkg::shift_high) begin
            // MOSI moves as sclk falls, MSB first
            tx_shift <= {tx_shift[zxuno_pkg::spi_bits-2:0], 1'b1};
            bit_cnt  <= bit_cnt + 1'b1;
         end
      end
   end

   // Sample on the rising sclk edge
   always_ff @(posedge clk) begin
      if (state == zxuno_pkg::shift_low) begin
         rx_shift <= {rx_shift[zxuno_pkg::spi_bits-2:0], miso};
      end
      // Result appears as busy drops
      if (state == zxuno_pkg::shift_high && last_bit) begin
         spi_rx_byte <= rx_shift;
      end
   end

   //////////////////////////////
   // Checks
   //////////////////////////////

   // Flash and SD share MISO, never drive both
   assert property (@(posedge clk) disable iff (!arst_n) !(!sd_cs_n && !flash_cs_n));

   // Clock parks low between bytes
   assert property (@(posedge clk) disable iff (!arst_n)
      (state == zxuno_pkg::idle) |-> !sclk);

   // Two cycles per bit
   assert property (@(posedge clk) disable iff (!arst_n)
      $rose(spi_busy) |-> spi_busy [*16] ##1 !spi_busy);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic arst_n
);

   // 4 ns period
   localparam int unsigned half_period_ns = 2;
   localparam int unsigned reset_cycles   = 10;

   initial begin
      clk = 1'b0;
      forever #(half_period_ns) clk = ~clk;
   end

   // Release away from the active edge
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* tb_tld_zxuno_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tld_zxuno_io;

   // Rough cycle budget per test
   localparam int unsigned len_reset  = 12;
   localparam int unsigned len_basic  = 8;
   localparam int unsigned len_ula    = 28;
   localparam int unsigned len_joy    = 32;
   localparam int unsigned len_sd     = 28;
   localparam int unsigned len_flash  = 32;
   localparam int unsigned len_cs     = 16;
   localparam int unsigned len_total  =
      len_reset + len_basic + len_ula + len_joy + len_sd + len_flash + len_cs;
   localparam int unsigned watchdog_ns = 2 * len_total * 4;

   wire        clk;
   wire        arst_n;
   logic [15:0] port_addr;
   logic [7:0]  wr_data;
   logic        iorq_wr;
   logic        iorq_rd;
   logic        ear;
   logic        joyup;
   logic        joydown;
   logic        joyleft;
   logic        joyright;
   logic        joyfire;
   wire  [7:0]  rd_data;
   wire         rd_valid;
   wire  [2:0]  border;
   wire         audio_out_left;
   wire         audio_out_right;
   wire         sd_cs_n;
   wire         sd_clk;
   wire         sd_mosi;
   wire         sd_miso;
   wire         flash_cs_n;
   wire         flash_clk;
   wire         flash_mosi;
   wire         flash_miso;
   wire         testled;
   wire         spi_busy;

   logic [31:0] lfsr = 32'h1e67_3233;
   int          check_count = 0;
   int          check_errors = 0;
   int          assert_errors = 0;

   // Transfer monitor state
   logic busy_prev = 1'b0;
   logic sclk_prev = 1'b0;
   int   busy_cycles = 0;
   int   sclk_rises = 0;

   tb_clock_gen tb_clock_gen_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   tld_zxuno_io tld_zxuno_io_i (
      .clk             (clk),
      .arst_n          (arst_n),
      .port_addr       (port_addr),
      .wr_data         (wr_data),
      .iorq_wr         (iorq_wr),
      .iorq_rd         (iorq_rd),
      .rd_data         (rd_data),
      .rd_valid        (rd_valid),
      .ear             (ear),
      .border          (border),
      .audio_out_left  (audio_out_left),
      .audio_out_right (audio_out_right),
      .joyup           (joyup),
      .joydown         (joydown),
      .joyleft         (joyleft),
      .joyright        (joyright),
      .joyfire         (joyfire),
      .sd_cs_n         (sd_cs_n),
      .sd_clk          (sd_clk),
      .sd_mosi         (sd_mosi),
      .sd_miso         (sd_miso),
      .flash_cs_n      (flash_cs_n),
      .flash_clk       (flash_clk),
      .flash_mosi      (flash_mosi),
      .flash_miso      (flash_miso),
      .testled         (testled)
   );

   // SD loops back inverted, flash straight
   assign sd_miso    = ~sd_mosi;
   assign flash_miso = flash_mosi;

   // Busy is internal to the SPI block
   assign spi_busy = tld_zxuno_io_i.spi_master_i.spi_busy;

   //////////////////////////////
   // Assertions
   //////////////////////////////

   assert property (@(posedge clk) disable iff (!arst_n) iorq_rd |=> rd_valid)
      else begin
         assert_errors++;
         $display("rd_valid did not rise one cycle after iorq_rd");
      end

   assert property (@(posedge clk) disable iff (!arst_n) rd_valid |-> $past(iorq_rd))
      else begin
         assert_errors++;
         $display("rd_valid rose without a read one cycle before");
      end

   assert property (@(posedge clk) disable iff (!arst_n) sd_cs_n || flash_cs_n)
      else begin
         assert_errors++;
         $display("SD card and flash were selected at the same time");
      end

   assert property (@(posedge clk) disable iff (!arst_n)
      (sd_clk == flash_clk) && (audio_out_left == audio_out_right))
      else begin
         assert_errors++;
         $display("Shared SPI clock or audio pins disagree");
      end

   // Counts busy cycles and sclk rises of the latest transfer
   always @(negedge clk) begin
      busy_prev <= spi_busy;
      sclk_prev <= sd_clk;
      if (spi_busy && !busy_prev) begin
         busy_cycles <= 1;
         sclk_rises  <= 0;
      end else if (spi_busy) begin
         busy_cycles <= busy_cycles + 1;
         if (sd_clk && !sclk_prev) begin
            sclk_rises <= sclk_rises + 1;
         end
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[6:0], lfsr[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      check_count++;
      if (actual !== expected) begin
         check_errors++;
         $display("ERROR %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic write_port(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk);
      port_addr <= addr;
      wr_data   <= data;
      iorq_wr   <= 1'b1;
      @(posedge clk);
      iorq_wr   <= 1'b0;
   endtask

   task automatic read_port(input logic [15:0] addr, output logic [7:0] data);
      bit seen;
      seen = 1'b0;
      @(posedge clk);
      port_addr <= addr;
      iorq_rd   <= 1'b1;
      @(posedge clk);
      iorq_rd   <= 1'b0;
      data = 8'hxx;
      for (int i = 0; i < 4 && !seen; i++) begin
         @(negedge clk);
         if (rd_valid) begin
            seen = 1'b1;
            data = rd_data;
         end
      end
      if (!seen) begin
         check_errors++;
         $display("No read response from port %h", addr);
      end
   endtask

   task automatic wait_spi_done();
      int i;
      i = 0;
      while (spi_busy && i < 40) begin
         @(negedge clk);
         i++;
      end
      if (spi_busy) begin
         check_errors++;
         $display("SPI transfer never finished");
      end
   endtask

   // Second write lands mid-transfer when intrude is set
   task automatic spi_exchange(input string name, input logic [7:0] tx, input bit intrude,
                               input logic [7:0] expected);
      logic [7:0] rx;
      write_port(16'h00EB, tx);
      if (intrude) begin
         write_port(16'h00EB, ~tx);
      end
      @(negedge clk);
      check_value({name, " testled"}, 8'h01, {7'b0, testled});
      wait_spi_done();
      check_value({name, " busy cycles"}, 8'd16, 8'(busy_cycles));
      check_value({name, " sclk rises"}, 8'd8, 8'(sclk_rises));
      read_port(16'h00EB, rx);
      check_value({name, " rx byte"}, expected, rx);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial begin
      logic [7:0] d;
      logic [7:0] rx;
      port_addr = 16'h0000;
      wr_data   = 8'h00;
      iorq_wr   = 1'b0;
      iorq_rd   = 1'b0;
      ear       = 1'b0;
      joyup     = 1'b1;
      joydown   = 1'b1;
      joyleft   = 1'b1;
      joyright  = 1'b1;
      joyfire   = 1'b1;

      @(posedge arst_n);
      @(negedge clk);

      // Reset state
      check_value("reset rd_valid", 8'h00, {7'b0, rd_valid});
      check_value("reset sd_clk", 8'h00, {7'b0, sd_clk});
      check_value("reset testled", 8'h00, {7'b0, testled});
      check_value("reset chip selects", 8'h03, {6'b0, flash_cs_n, sd_cs_n});
      check_value("reset border", 8'h00, {5'b0, border});
      read_port(16'h00FF, rx);
      check_value("unmapped read", 8'hFF, rx);

      // Border and beeper
      take_bits(8, d);
      write_port(16'h12FE, d);
      @(negedge clk);
      check_value("fe border", {5'b0, d[2:0]}, {5'b0, border});
      check_value("fe audio", {7'b0, d[4] ^ d[3]}, {7'b0, audio_out_left});
      read_port(16'h00FE, rx);
      check_value("fe ear low", 8'hFF, rx);
      @(posedge clk);
      ear <= 1'b1;
      repeat (3) @(posedge clk);
      read_port(16'h00FE, rx);
      check_value("fe ear high", 8'hBF, rx);

      // Unmapped port must not follow the ULA byte
      read_port(16'h00FF, rx);
      check_value("unmapped read ear high", 8'hFF, rx);

      // Kempston patterns
      for (int k = 0; k < 4; k++) begin
         take_bits(5, d);
         @(posedge clk);
         joyright <= d[0];
         joyleft  <= d[1];
         joydown  <= d[2];
         joyup    <= d[3];
         joyfire  <= d[4];
         repeat (3) @(posedge clk);
         read_port(16'h001F, rx);
         check_value("kempston", {3'b000, ~d[4:0]}, rx);
      end

      // SD card exchange
      write_port(16'h00E7, 8'h02);
      take_bits(8, d);
      spi_exchange("sd exchange", d, 1'b0, ~d);

      // Flash exchange with an ignored write
      write_port(16'h00E7, 8'h01);
      take_bits(8, d);
      spi_exchange("flash exchange", d, 1'b1, d);

      // LED follows chip selects
      write_port(16'h00E7, 8'h03);
      repeat (2) @(negedge clk);
      check_value("cs 3 testled", 8'h00, {7'b0, testled});
      write_port(16'h00E7, 8'h00);
      repeat (2) @(negedge clk);
      check_value("cs 0 testled", 8'h01, {7'b0, testled});

      repeat (2) @(posedge clk);
      $display("Checks %0d, value errors %0d, assertion errors %0d",
               check_count, check_errors, assert_errors);
      if (check_errors == 0 && assert_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(watchdog_ns);
      $display("Timeout, the tests did not finish within %0d ns", watchdog_ns);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* tld_zxuno_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tld_zxuno_io (
   input  wire        clk,
   input  wire        arst_n,

   // Z80 port bus
   input  wire [15:0] port_addr,
   input  wire [7:0]  wr_data,
   input  wire        iorq_wr,
   input  wire        iorq_rd,
   output wire [7:0]  rd_data,
   output wire        rd_valid,

   // ULA pins
   input  wire        ear,
   output wire [2:0]  border,
   output wire        audio_out_left,
   output wire        audio_out_right,

   // Joystick, active low
   input  wire        joyup,
   input  wire        joydown,
   input  wire        joyleft,
   input  wire        joyright,
   input  wire        joyfire,

   // SD card and boot flash
   output wire        sd_cs_n,
   output wire        sd_clk,
   output wire        sd_mosi,
   input  wire        sd_miso,
   output wire        flash_cs_n,
   output wire        flash_clk,
   output wire        flash_mosi,
   input  wire        flash_miso,

   // SPI activity
   output wire        testled
);

   wire       ula_wr;
   wire       cs_wr;
   wire       spi_wr;
   wire [7:0] ula_rd_byte;
   wire [7:0] joy_byte;
   wire [7:0] spi_rx_byte;
   wire       sclk;
   wire       mosi;
   wire       audio_out;

   //////////////////////////////
   // Pin sharing
   //////////////////////////////

   // Mono beeper on both channels
   assign audio_out_left  = audio_out;
   assign audio_out_right = audio_out;

   // One SPI bus, two chip selects
   assign sd_clk     = sclk;
   assign flash_clk  = sclk;
   assign sd_mosi    = mosi;
   assign flash_mosi = mosi;

   io_port_decoder io_port_decoder_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .port_addr   (port_addr),
      .iorq_wr     (iorq_wr),
      .iorq_rd     (iorq_rd),
      .ula_rd_byte (ula_rd_byte),
      .joy_byte    (joy_byte),
      .spi_rx_byte (spi_rx_byte),
      .ula_wr      (ula_wr),
      .cs_wr       (cs_wr),
      .spi_wr      (spi_wr),
      .rd_data     (rd_data),
      .rd_valid    (rd_valid)
   );

   ula_port_fe ula_port_fe_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .ula_wr      (ula_wr),
      .wr_data     (wr_data),
      .ear         (ear),
      .border      (border),
      .audio_out   (audio_out),
      .ula_rd_byte (ula_rd_byte)
   );

   kempston_joy kempston_joy_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .joyup    (joyup),
      .joydown  (joydown),
      .joyleft  (joyleft),
      .joyright (joyright),
      .joyfire  (joyfire),
      .joy_byte (joy_byte)
   );

   // Busy only feeds the transfer check inside
   spi_master spi_master_i (
      .clk         (clk),
      .arst_n      (arst_n),
      .cs_wr       (cs_wr),
      .spi_wr      (spi_wr),
      .wr_data     (wr_data),
      .sd_miso     (sd_miso),
      .flash_miso  (flash_miso),
      .spi_rx_byte (spi_rx_byte),
      .spi_busy    (),
      .sd_cs_n     (sd_cs_n),
      .flash_cs_n  (flash_cs_n),
      .sclk        (sclk),
      .mosi        (mosi),
      .testled     (testled)
   );

endmodule

`default_nettype wire

/* ula_port_fe.sv */
`timescale 1ns/1ps
`default_nettype none

module ula_port_fe (
   input  wire        clk,
   input  wire        arst_n,
   input  wire        ula_wr,
   input  wire [7:0]  wr_data,
   input  wire        ear,
   output logic [2:0] border,
   output logic       audio_out,
   output logic [7:0] ula_rd_byte
);

   logic mic;
   logic beep;
   logic ear_meta;
   logic ear_sync;

   //////////////////////////////
   // Write side
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         border <= '0;
         mic    <= 1'b0;
         beep   <= 1'b0;
      end else if (ula_wr) begin
         border <= wr_data[zxuno_pkg::fe_border_lsb +: zxuno_pkg::fe_border_w];
         mic    <= wr_data[zxuno_pkg::fe_mic_bit];
         beep   <= wr_data[zxuno_pkg::fe_beep_bit];
      end
   end

   // Speaker and MIC share one audio pin
   assign audio_out = beep ^ mic;

   //////////////////////////////
   // Read side
   //////////////////////////////

   // Board has a transistor inverter on EAR
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ear_meta <= 1'b0;
         ear_sync <= 1'b0;
      end else begin
         ear_meta <= ~ear;
         ear_sync <= ear_meta;
      end
   end

   // No keyboard, so all key bits read released
   always_comb begin
      ula_rd_byte = zxuno_pkg::idle_read_value;
      ula_rd_byte[zxuno_pkg::fe_ear_bit] = ear_sync;
   end

endmodule

`default_nettype wire

/* verilog.f */
zxuno_pkg.sv
io_port_decoder.sv
spi_master.sv
kempston_joy.sv
ula_port_fe.sv
tld_zxuno_io.sv
tb_clock_gen.sv
tb_tld_zxuno_io.sv

/* zxuno_pkg.sv */
`default_nettype none

package zxuno_pkg;

   //////////////////////////////
   // Port decode
   //////////////////////////////

   // ULA answers to any even port
   localparam int unsigned port_fe_bit = 0;

   // Exact low-byte matches
   localparam logic [7:0] port_kempston = 8'h1F;
   localparam logic [7:0] port_spi_cs   = 8'hE7;
   localparam logic [7:0] port_spi_data = 8'hEB;

   // Unmapped ports float high on the Z80 bus
   localparam logic [7:0] idle_read_value = 8'hFF;

   // Block picked by the decoder
   typedef enum logic [2:0] {
      none     = 3'd0,
      ula      = 3'd1,
      joy      = 3'd2,
      spi_cs   = 3'd3,
      spi_data = 3'd4
   } io_target_e;

   //////////////////////////////
   // SPI
   //////////////////////////////

   // Chip select bits in E7, active low on the bus
   localparam int unsigned cs_sd_bit    = 0;
   localparam int unsigned cs_flash_bit = 1;

   localparam int unsigned spi_bits = 8;

   // Two clk cycles per SPI bit
   typedef enum logic [1:0] {
      idle       = 2'd0,
      shift_low  = 2'd1,
      shift_high = 2'd2
   } spi_state_e;

   //////////////////////////////
   // ULA port FE
   //////////////////////////////

   localparam int unsigned fe_border_lsb = 0;
   localparam int unsigned fe_border_w   = 3;
   localparam int unsigned fe_mic_bit    = 3;
   localparam int unsigned fe_beep_bit   = 4;
   localparam int unsigned fe_ear_bit    = 6;

endpackage

`default_nettype wire
